//--- filelist.f
+incdir+.
lsu_pkg.sv
lsu_req_format.sv
lsu_load_align.sv
lsu_bus_timeout.sv
lsu_task_table.sv
lsu_top.sv
tb_lsu_clkgen.sv
tb_lsu_checker.sv
tb_lsu.sv

//--- Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_lsu
FILELIST := filelist.f
LOG := sim.log
OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(BIN) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu;

	localparam int RESET_CYCLES = 16;
	localparam int N_RANDOM = 60;
	localparam int N_DIRECTED = 46 + 6 + 5 + 1; // widths, misaligned, error region, timeout
	localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 40;
	localparam lsu_pkg::ls_type_t LOAD_TYPES [5] = '{`LS_TYPE_BYTE, `LS_TYPE_HALF,
		`LS_TYPE_WORD, `LS_TYPE_BYTE_U, `LS_TYPE_HALF_U};

	logic clk;
	logic resetn;
	lsu_pkg::ls_req_t req;
	logic req_valid;
	logic req_ready;
	lsu_pkg::ls_resp_t resp;
	logic resp_valid;
	logic resp_ready = 1'b0;
	lsu_pkg::icb_cmd_t icb_cmd;
	logic icb_cmd_valid;
	logic icb_cmd_ready = 1'b0;
	lsu_pkg::icb_rsp_t icb_rsp = '0;
	logic icb_rsp_valid = 1'b0;
	logic icb_rsp_ready;
	logic lsu_idle;
	logic dbus_timeout;
	logic slave_mute;
	int errors;
	int checks;
	int pending;

	lsu_pkg::word_t slave_mem [256];
	lsu_pkg::icb_rsp_t rsp_q [$]; // answers in command order
	int due_q [$];
	int cycle_cnt = 0;
	lsu_pkg::inst_id_t next_id;
	int n_issued;

	tb_lsu_clkgen u_clkgen (
		.clk_o (clk)
	);

	lsu_top UUT (
		.clk             (clk),
		.resetn          (resetn),
		.req_i           (req),
		.req_valid_i     (req_valid),
		.req_ready_o     (req_ready),
		.resp_o          (resp),
		.resp_valid_o    (resp_valid),
		.resp_ready_i    (resp_ready),
		.icb_cmd_o       (icb_cmd),
		.icb_cmd_valid_o (icb_cmd_valid),
		.icb_cmd_ready_i (icb_cmd_ready),
		.icb_rsp_i       (icb_rsp),
		.icb_rsp_valid_i (icb_rsp_valid),
		.icb_rsp_ready_o (icb_rsp_ready),
		.lsu_idle_o      (lsu_idle),
		.dbus_timeout_o  (dbus_timeout)
	);

	tb_lsu_checker u_checker (
		.clk_i           (clk),
		.resetn_i        (resetn),
		.req_i           (req),
		.req_valid_i     (req_valid),
		.req_ready_i     (req_ready),
		.resp_i          (resp),
		.resp_valid_i    (resp_valid),
		.resp_ready_i    (resp_ready),
		.icb_cmd_i       (icb_cmd),
		.icb_cmd_valid_i (icb_cmd_valid),
		.icb_cmd_ready_i (icb_cmd_ready),
		.icb_rsp_ready_i (icb_rsp_ready),
		.lsu_idle_i      (lsu_idle),
		.dbus_timeout_i  (dbus_timeout),
		.slave_mute_i    (slave_mute),
		.errors_o        (errors),
		.checks_o        (checks),
		.pending_o       (pending)
	);

	function automatic lsu_pkg::word_t fill_word(input int idx);
		logic [7:0] a;
		a = 8'(idx);
		return {a ^ 8'h96, a, ~a, a ^ 8'h3c};
	endfunction

	// top nibble F marks the error region where nothing is written
	task automatic serve_command(input lsu_pkg::icb_cmd_t c);
		lsu_pkg::icb_rsp_t r;
		logic [7:0] idx;
		idx = c.addr[9:2];
		r.err = (c.addr[31:28] == 4'hf);
		r.rdata = '0;
		if (!r.err)
		begin
			if (c.read)
				r.rdata = slave_mem[idx];
			else
				for (int b = 0; b < 4; b++)
					if (c.wmask[b])
						slave_mem[idx][8*b +: 8] = c.wdata[8*b +: 8];
		end
		rsp_q.push_back(r);
		due_q.push_back(cycle_cnt + 1 + int'($urandom_range(3))); // 1 to 4 cycles
	endtask

	always @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < 256; i++)
				slave_mem[i] = fill_word(i);
		end
		else
		begin
			if (icb_rsp_valid && icb_rsp_ready)
			begin
				void'(rsp_q.pop_front());
				void'(due_q.pop_front());
			end
			if (icb_cmd_valid && icb_cmd_ready)
				serve_command(icb_cmd);
			cycle_cnt++;
		end
	end

	always @(negedge clk)
	begin
		icb_cmd_ready = ($urandom_range(3) != 0);
		resp_ready = ($urandom_range(3) != 0);
		if (!slave_mute && (rsp_q.size() != 0) && (cycle_cnt >= due_q[0]))
		begin
			icb_rsp_valid = 1'b1;
			icb_rsp = rsp_q[0];
		end
		else
		begin
			icb_rsp_valid = 1'b0;
			icb_rsp = '0;
		end
	end

	// holds valid until accepted; valid stays up for a back-to-back request
	task automatic issue(input logic st, input lsu_pkg::ls_type_t t, input lsu_pkg::word_t addr,
		input lsu_pkg::word_t wdata);
		@(negedge clk);
		req = '{is_store: st, ls_type: t, rd_id: 5'($urandom_range(31)), addr: addr,
			wdata: wdata, inst_id: next_id};
		req_valid = 1'b1;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
		next_id = next_id + 1'b1;
		n_issued++;
	endtask

	task automatic issue_random();
		logic st;
		lsu_pkg::ls_type_t t;
		lsu_pkg::word_t addr;
		int size;
		st = ($urandom_range(1) != 0);
		if (st)
			t = 3'($urandom_range(2)); // byte, half or word
		else
			t = LOAD_TYPES[$urandom_range(4)];
		size = t[1] ? 4 : (t[0] ? 2 : 1);
		addr = {22'd0, 8'($urandom_range(255)), 2'b00};
		if ($urandom_range(9) == 0)
			addr[1:0] = 2'($urandom_range(3)); // sometimes misaligned
		else
			addr[1:0] = 2'((int'($urandom_range(3)) / size) * size);
		if ($urandom_range(9) == 0)
			addr[31:28] = 4'hf;
		issue(st, t, addr, $urandom());
	endtask

	task automatic drain();
		@(negedge clk);
		req_valid = 1'b0;
		while (pending != 0)
			@(negedge clk);
	endtask

	initial
	begin
		void'($urandom(80));
		resetn = 1'b0;
		req = '0;
		req_valid = 1'b0;
		slave_mute = 1'b0;
		next_id = '0;
		n_issued = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		resetn = 1'b1;

		// every store width, then every load type at each offset
		issue(1'b1, `LS_TYPE_WORD, 32'h40, $urandom());
		for (int b = 0; b < 4; b++)
			issue(1'b1, `LS_TYPE_BYTE, 32'h44 + b, 32'h0180ff7f >> (8 * b));
		issue(1'b1, `LS_TYPE_HALF, 32'h48, 32'h8001);
		issue(1'b1, `LS_TYPE_HALF, 32'h4a, 32'h7ffe);
		for (int a = 'h40; a < 'h4c; a += 4)
		begin
			for (int b = 0; b < 4; b++)
			begin
				issue(1'b0, `LS_TYPE_BYTE, a + b, '0);
				issue(1'b0, `LS_TYPE_BYTE_U, a + b, '0);
			end
			for (int b = 0; b < 4; b += 2)
			begin
				issue(1'b0, `LS_TYPE_HALF, a + b, '0);
				issue(1'b0, `LS_TYPE_HALF_U, a + b, '0);
			end
			issue(1'b0, `LS_TYPE_WORD, a, '0);
		end

		issue(1'b0, `LS_TYPE_HALF, 32'h51, '0);
		issue(1'b1, `LS_TYPE_HALF, 32'h53, $urandom());
		issue(1'b0, `LS_TYPE_WORD, 32'h52, '0);
		issue(1'b1, `LS_TYPE_WORD, 32'h41, $urandom());
		issue(1'b0, `LS_TYPE_HALF_U, 32'h45, '0);
		issue(1'b0, `LS_TYPE_WORD, 32'h40, '0); // misaligned store left no trace

		issue(1'b1, `LS_TYPE_WORD, 32'hf0000050, $urandom());
		issue(1'b0, `LS_TYPE_WORD, 32'hf0000054, '0);
		issue(1'b0, `LS_TYPE_BYTE, 32'hf0000041, '0);
		issue(1'b0, `LS_TYPE_WORD, 32'h50, '0);
		issue(1'b0, `LS_TYPE_WORD, 32'h54, '0);

		for (int n = 0; n < N_RANDOM; n++)
			issue_random();
		drain();

		// a silent slave makes the last access time out
		slave_mute = 1'b1;
		issue(1'b0, `LS_TYPE_WORD, 32'h60, '0);
		drain();
		req_valid = 1'b1;
		repeat (8) @(negedge clk);
		req_valid = 1'b0;
		@(negedge clk);

		$display("done: %0d errors in %0d checks, %0d requests, %0d results pending",
			errors, checks, n_issued, pending);
		if ((errors == 0) && (pending == 0))
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, %0d requests issued, %0d results pending",
			WATCHDOG_CYCLES, n_issued, pending);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tb_lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_checker (
	input  logic clk_i,
	input  logic resetn_i,
	input  lsu_pkg::ls_req_t req_i,
	input  logic req_valid_i,
	input  logic req_ready_i,
	input  lsu_pkg::ls_resp_t resp_i,
	input  logic resp_valid_i,
	input  logic resp_ready_i,
	input  lsu_pkg::icb_cmd_t icb_cmd_i,
	input  logic icb_cmd_valid_i,
	input  logic icb_cmd_ready_i,
	input  logic icb_rsp_ready_i,
	input  logic lsu_idle_i,
	input  logic dbus_timeout_i,
	input  logic slave_mute_i, // bus slave has gone silent
	output int errors_o,
	output int checks_o,
	output int pending_o
);

	lsu_pkg::word_t mem [256]; // reference copy of the slave memory
	lsu_pkg::ls_resp_t exp_q [$];
	lsu_pkg::icb_cmd_t cmd_q [$];
	int error_cnt = 0;
	int check_cnt = 0;
	int pending_cnt = 0;

	assign errors_o = error_cnt;
	assign checks_o = check_cnt;
	assign pending_o = pending_cnt;

	function automatic lsu_pkg::word_t fill_word(input int idx);
		logic [7:0] a;
		a = 8'(idx);
		return {a ^ 8'h96, a, ~a, a ^ 8'h3c};
	endfunction

	function automatic int access_size(input lsu_pkg::ls_type_t t);
		if ((t == `LS_TYPE_WORD))
			return 4;
		else if ((t == `LS_TYPE_HALF) || (t == `LS_TYPE_HALF_U))
			return 2;
		return 1;
	endfunction

	// byte lanes touched by the access
	function automatic lsu_pkg::wmask_t lane_mask(input lsu_pkg::ls_req_t r);
		lsu_pkg::wmask_t m;
		int off;
		int size;
		off = int'(r.addr[1:0]);
		size = access_size(r.ls_type);
		m = '0;
		for (int b = 0; b < 4; b++)
			m[b] = (b >= off) && (b < off + size);
		return m;
	endfunction

	// expected result straight from the access rules
	function automatic lsu_pkg::ls_resp_t expect_resp(input lsu_pkg::ls_req_t r, input logic muted);
		lsu_pkg::ls_resp_t e;
		lsu_pkg::word_t raw;
		int size;
		int off;
		logic bus_err;
		logic signed_ld;
		size = access_size(r.ls_type);
		off = int'(r.addr[1:0]);
		bus_err = (r.addr[31:28] == 4'hf);
		signed_ld = (r.ls_type == `LS_TYPE_BYTE) || (r.ls_type == `LS_TYPE_HALF);
		e = '0;
		e.is_store = r.is_store;
		e.rd_id = r.rd_id;
		e.addr = r.addr;
		e.inst_id = r.inst_id;
		if ((off % size) != 0)
			e.err = `ERR_UNALIGNED;
		else if (muted)
			e.err = `ERR_TIMEOUT;
		else if (bus_err)
			e.err = `ERR_BUS;
		else
			e.err = `ERR_NORMAL;
		if (r.is_store)
		begin
			for (int b = 0; b < 4; b++)
				e.data[8*b +: 8] = r.wdata[8*(b % size) +: 8]; // lane replication
		end
		else if (!bus_err)
		begin
			raw = mem[r.addr[9:2]] >> (8 * off);
			for (int b = 0; b < 4; b++)
				e.data[8*b +: 8] = (b < size) ? raw[8*b +: 8] : {8{signed_ld & raw[8*size-1]}};
		end
		return e;
	endfunction

	task automatic commit_store(input lsu_pkg::ls_req_t r, input lsu_pkg::ls_resp_t e);
		lsu_pkg::wmask_t m;
		m = lane_mask(r);
		if (r.is_store && (e.err == `ERR_NORMAL))
		begin
			for (int b = 0; b < 4; b++)
				if (m[b])
					mem[r.addr[9:2]][8*b +: 8] = e.data[8*b +: 8];
		end
	endtask

	task automatic compare_field(input string name, input lsu_pkg::word_t got,
		input lsu_pkg::word_t want);
		check_cnt++;
		if (got !== want)
		begin
			error_cnt++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic flag_failure(input string what);
		error_cnt++;
		$display("failure at %0t: %s", $time, what);
	endtask

	always @(posedge clk_i)
	begin
		lsu_pkg::ls_resp_t want;
		lsu_pkg::icb_cmd_t cmd_want;
		if (!resetn_i)
		begin
			for (int i = 0; i < 256; i++)
				mem[i] = fill_word(i);
		end
		else
		begin
			// nothing outstanding means nothing in flight
			if (exp_q.size() == 0)
				compare_field("lsu_idle_o", 32'(lsu_idle_i), 32'd1);
			if (dbus_timeout_i && (req_ready_i || icb_cmd_valid_i || icb_rsp_ready_i))
				flag_failure("a channel is still open after the bus timeout");
			if (req_valid_i && req_ready_i)
			begin
				want = expect_resp(req_i, slave_mute_i);
				commit_store(req_i, want);
				exp_q.push_back(want);
				if (want.err != `ERR_UNALIGNED)
					cmd_q.push_back('{addr: req_i.addr, read: ~req_i.is_store,
						wdata: want.data, wmask: lane_mask(req_i)});
			end
			if (icb_cmd_valid_i && icb_cmd_ready_i)
			begin
				if (cmd_q.size() == 0)
					flag_failure("bus command issued with no aligned request outstanding");
				else
				begin
					cmd_want = cmd_q.pop_front();
					compare_field("icb_cmd_o.addr", icb_cmd_i.addr, cmd_want.addr);
					compare_field("icb_cmd_o.read", 32'(icb_cmd_i.read), 32'(cmd_want.read));
					if (!cmd_want.read)
					begin
						compare_field("icb_cmd_o.wdata", icb_cmd_i.wdata, cmd_want.wdata);
						compare_field("icb_cmd_o.wmask", 32'(icb_cmd_i.wmask),
							32'(cmd_want.wmask));
					end
				end
			end
			if (resp_valid_i && resp_ready_i)
			begin
				if (exp_q.size() == 0)
					flag_failure("result retired with no request outstanding");
				else
				begin
					want = exp_q.pop_front();
					compare_field("resp_o.inst_id", 32'(resp_i.inst_id), 32'(want.inst_id));
					compare_field("resp_o.rd_id", 32'(resp_i.rd_id), 32'(want.rd_id));
					compare_field("resp_o.is_store", 32'(resp_i.is_store), 32'(want.is_store));
					compare_field("resp_o.addr", resp_i.addr, want.addr);
					compare_field("resp_o.err", 32'(resp_i.err), 32'(want.err));
					if ((want.err == `ERR_NORMAL) || (want.err == `ERR_BUS))
						compare_field("resp_o.data", resp_i.data, want.data);
					if (want.err == `ERR_TIMEOUT)
						compare_field("dbus_timeout_o", 32'(dbus_timeout_i), 32'd1);
				end
			end
			pending_cnt = exp_q.size();
		end
	end

endmodule

//--- tb_lsu_clkgen.sv
`timescale 1ns/1ps

module tb_lsu_clkgen (
	output logic clk_o
);

	localparam int HALF_PERIOD = 50; // 100 ns clock

	initial
	begin
		clk_o = 1'b0;
		forever
			#HALF_PERIOD clk_o = ~clk_o;
	end

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
	input  logic clk,
	input  logic resetn,
	input  lsu_pkg::ls_req_t req_i,
	input  logic req_valid_i,
	output logic req_ready_o,
	output lsu_pkg::ls_resp_t resp_o,
	output logic resp_valid_o,
	input  logic resp_ready_i,
	output lsu_pkg::icb_cmd_t icb_cmd_o,
	output logic icb_cmd_valid_o,
	input  logic icb_cmd_ready_i,
	input  lsu_pkg::icb_rsp_t icb_rsp_i,
	input  logic icb_rsp_valid_i,
	output logic icb_rsp_ready_o,
	output logic lsu_idle_o,
	output logic dbus_timeout_o
);

	logic aligned;
	lsu_pkg::word_t store_data;
	lsu_pkg::wmask_t store_wmask;
	logic bus_busy;
	logic rsp_fire;
	logic timeout_pulse;
	lsu_pkg::ls_entry_t head;
	lsu_pkg::word_t load_data;

	lsu_req_format u_req_format (
		.req_i         (req_i),
		.aligned_o     (aligned),
		.store_data_o  (store_data),
		.store_wmask_o (store_wmask)
	);

	lsu_task_table u_task_table (
		.clk             (clk),
		.resetn          (resetn),
		.req_i           (req_i),
		.req_valid_i     (req_valid_i),
		.aligned_i       (aligned),
		.store_data_i    (store_data),
		.store_wmask_i   (store_wmask),
		.req_ready_o     (req_ready_o),
		.icb_cmd_o       (icb_cmd_o),
		.icb_cmd_valid_o (icb_cmd_valid_o),
		.icb_cmd_ready_i (icb_cmd_ready_i),
		.icb_rsp_i       (icb_rsp_i),
		.rsp_fire_i      (rsp_fire),
		.timeout_pulse_i (timeout_pulse),
		.timeout_i       (dbus_timeout_o),
		.bus_busy_o      (bus_busy),
		.head_o          (head),
		.head_valid_o    (resp_valid_o),
		.resp_ready_i    (resp_ready_i),
		.lsu_idle_o      (lsu_idle_o)
	);

	lsu_bus_timeout u_bus_timeout (
		.clk             (clk),
		.resetn          (resetn),
		.rsp_valid_i     (icb_rsp_valid_i),
		.bus_busy_i      (bus_busy),
		.rsp_ready_o     (icb_rsp_ready_o),
		.rsp_fire_o      (rsp_fire),
		.timeout_pulse_o (timeout_pulse),
		.timeout_o       (dbus_timeout_o)
	);

	lsu_load_align u_load_align (
		.entry_i     (head),
		.load_data_o (load_data)
	);

	// result = head entry with the extended load data
	assign resp_o = '{is_store: head.is_store, rd_id: head.rd_id, data: load_data,
		addr: head.addr, err: head.err, inst_id: head.inst_id};

endmodule

//--- lsu_task_table.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_task_table (
	input  logic clk,
	input  logic resetn,
	input  lsu_pkg::ls_req_t req_i,
	input  logic req_valid_i,
	input  logic aligned_i,
	input  lsu_pkg::word_t store_data_i,
	input  lsu_pkg::wmask_t store_wmask_i,
	output logic req_ready_o,
	output lsu_pkg::icb_cmd_t icb_cmd_o,
	output logic icb_cmd_valid_o,
	input  logic icb_cmd_ready_i,
	input  lsu_pkg::icb_rsp_t icb_rsp_i,
	input  logic rsp_fire_i,
	input  logic timeout_pulse_i,
	input  logic timeout_i,
	output logic bus_busy_o,
	output lsu_pkg::ls_entry_t head_o,
	output logic head_valid_o,
	input  logic resp_ready_i,
	output logic lsu_idle_o
);

	lsu_pkg::ls_entry_t entry_q [`LSU_TABLE_DEPTH];
	lsu_pkg::task_stage_e stage_q [`LSU_TABLE_DEPTH];

	logic [`LSU_PTR_W-1:0] launch_ptr; // next free slot
	logic [`LSU_PTR_W-1:0] cmd_ptr; // oldest entry not yet on the bus
	logic [`LSU_PTR_W-1:0] rsp_ptr; // oldest entry awaiting a response
	logic [`LSU_PTR_W-1:0] retire_ptr; // head of the table
	logic [`LSU_CNT_W-1:0] launched_cnt;
	logic [`LSU_CNT_W-1:0] onbus_cnt;

	logic full;
	logic empty;
	logic launch;
	logic unaligned_launch;
	logic bypass;
	logic cmd_pending;
	logic cmd_fire;
	logic rsp_done;
	logic retire;

	assign full = (launched_cnt == `LSU_CNT_W'(`LSU_TABLE_DEPTH));
	assign empty = (launched_cnt == '0);

	// a misaligned request waits until the table drains
	assign req_ready_o = ~full & ~timeout_i & (aligned_i | empty);
	assign launch = req_valid_i & req_ready_o;
	assign unaligned_launch = launch & ~aligned_i;

	assign cmd_pending = (stage_q[cmd_ptr] == lsu_pkg::STAGE_CMD);
	assign bypass = launch & aligned_i & ~cmd_pending;
	assign icb_cmd_valid_o = ~timeout_i & (cmd_pending | (launch & aligned_i));
	assign cmd_fire = icb_cmd_valid_o & icb_cmd_ready_i;
	assign rsp_done = rsp_fire_i | timeout_pulse_i;

	assign head_o = entry_q[retire_ptr];
	assign head_valid_o = (stage_q[retire_ptr] == lsu_pkg::STAGE_DONE);
	assign retire = head_valid_o & resp_ready_i;
	assign bus_busy_o = (onbus_cnt != '0);

	always_comb
	begin
		if (cmd_pending)
			icb_cmd_o = '{addr: entry_q[cmd_ptr].addr, read: ~entry_q[cmd_ptr].is_store,
				wdata: entry_q[cmd_ptr].data, wmask: entry_q[cmd_ptr].wmask};
		else
			icb_cmd_o = '{addr: req_i.addr, read: ~req_i.is_store,
				wdata: store_data_i, wmask: store_wmask_i}; // request bypass
	end

	always_comb
	begin
		lsu_idle_o = 1'b1;
		for (int i = 0; i < `LSU_TABLE_DEPTH; i++)
		begin
			if ((stage_q[i] == lsu_pkg::STAGE_CMD) || (stage_q[i] == lsu_pkg::STAGE_RESP))
				lsu_idle_o = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			launch_ptr <= '0;
			cmd_ptr <= '0;
			rsp_ptr <= '0;
			retire_ptr <= '0;
			launched_cnt <= '0;
			onbus_cnt <= '0;
		end
		else
		begin
			launch_ptr <= launch_ptr + `LSU_PTR_W'(launch);
			// misaligned entries skip both bus stages
			cmd_ptr <= cmd_ptr + `LSU_PTR_W'(cmd_fire | unaligned_launch);
			rsp_ptr <= rsp_ptr + `LSU_PTR_W'(rsp_done | unaligned_launch);
			retire_ptr <= retire_ptr + `LSU_PTR_W'(retire);
			if (launch && !retire)
				launched_cnt <= launched_cnt + 1'b1;
			else if (!launch && retire)
				launched_cnt <= launched_cnt - 1'b1;
			if (cmd_fire && !rsp_done)
				onbus_cnt <= onbus_cnt + 1'b1;
			else if (!cmd_fire && rsp_done)
				onbus_cnt <= onbus_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < `LSU_TABLE_DEPTH; i++)
				stage_q[i] <= lsu_pkg::STAGE_FREE;
		end
		else
		begin
			for (int i = 0; i < `LSU_TABLE_DEPTH; i++)
			begin
				case (stage_q[i])
					lsu_pkg::STAGE_FREE:
						if (launch && (launch_ptr == `LSU_PTR_W'(i)))
							stage_q[i] <= !aligned_i ? lsu_pkg::STAGE_DONE :
								((bypass && icb_cmd_ready_i) ? lsu_pkg::STAGE_RESP :
								lsu_pkg::STAGE_CMD);
					lsu_pkg::STAGE_CMD:
						if (cmd_fire && (cmd_ptr == `LSU_PTR_W'(i)))
							stage_q[i] <= lsu_pkg::STAGE_RESP;
					lsu_pkg::STAGE_RESP:
						if (rsp_done && (rsp_ptr == `LSU_PTR_W'(i)))
							stage_q[i] <= lsu_pkg::STAGE_DONE;
					lsu_pkg::STAGE_DONE:
						if (retire && (retire_ptr == `LSU_PTR_W'(i)))
							stage_q[i] <= lsu_pkg::STAGE_FREE;
				endcase
			end
		end
	end

	// payload, launch and response never hit the same slot
	always_ff @(posedge clk)
	begin
		if (launch)
			entry_q[launch_ptr] <= '{is_store: req_i.is_store, ls_type: req_i.ls_type,
				rd_id: req_i.rd_id, addr: req_i.addr, data: store_data_i,
				wmask: store_wmask_i, err: aligned_i ? `ERR_NORMAL : `ERR_UNALIGNED,
				inst_id: req_i.inst_id};
		if (rsp_fire_i)
		begin
			if (!entry_q[rsp_ptr].is_store)
				entry_q[rsp_ptr].data <= icb_rsp_i.rdata;
			entry_q[rsp_ptr].err <= icb_rsp_i.err ? `ERR_BUS : `ERR_NORMAL;
		end
		else if (timeout_pulse_i)
			entry_q[rsp_ptr].err <= `ERR_TIMEOUT;
	end

	assert property (@(posedge clk) disable iff (!resetn)
		launch |-> (stage_q[launch_ptr] == lsu_pkg::STAGE_FREE))
		else $error("launch into an occupied slot");

	assert property (@(posedge clk) disable iff (!resetn)
		retire |-> ((stage_q[retire_ptr] == lsu_pkg::STAGE_DONE) && (launched_cnt != '0)))
		else $error("retire from an entry that is not done");

	// a stalled command holds until taken, unless the bus timed out
	assert property (@(posedge clk) disable iff (!resetn)
		(icb_cmd_valid_o && !icb_cmd_ready_i) |=>
		(timeout_i || (icb_cmd_valid_o && $stable(icb_cmd_o))))
		else $error("command changed while stalled");

endmodule

//--- lsu_bus_timeout.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_bus_timeout (
	input  logic clk,
	input  logic resetn,
	input  logic rsp_valid_i,
	input  logic bus_busy_i, // at least one command awaits its response
	output logic rsp_ready_o,
	output logic rsp_fire_o,
	output logic timeout_pulse_o,
	output logic timeout_o
);

	localparam int CNT_W = $clog2(`LSU_TIMEOUT_TH + 1);

	logic [CNT_W-1:0] wait_cnt;
	logic timeout_q;
	logic pulse_q;
	logic expire;

	// response channel closes for good after a timeout
	assign rsp_ready_o = ~timeout_q;
	assign rsp_fire_o = rsp_valid_i & rsp_ready_o;

	assign expire = ~timeout_q & ~rsp_fire_o & bus_busy_i &
		(wait_cnt == CNT_W'(`LSU_TIMEOUT_TH - 1));

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			wait_cnt <= '0;
		else if (!timeout_q)
		begin
			if (rsp_fire_o)
				wait_cnt <= '0;
			else if (bus_busy_i)
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			timeout_q <= 1'b0;
			pulse_q <= 1'b0;
		end
		else
		begin
			timeout_q <= timeout_q | expire; // sticky until reset
			pulse_q <= expire;
		end
	end

	assign timeout_o = timeout_q;
	assign timeout_pulse_o = pulse_q;

	// the pulse marks the single rising edge of the sticky level
	assert property (@(posedge clk) disable iff (!resetn)
		timeout_pulse_o |-> (timeout_o && !$past(timeout_o)))
		else $error("timeout pulse without a fresh timeout");

endmodule

//--- lsu_load_align.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_load_align (
	input  lsu_pkg::ls_entry_t entry_i,
	output lsu_pkg::word_t load_data_o
);

	lsu_pkg::word_t shifted; // addressed byte moved to bit 0

	assign shifted = entry_i.data >> {entry_i.addr[1:0], 3'b000};

	always_comb
	begin
		if (entry_i.is_store)
			load_data_o = entry_i.data;
		else
		begin
			case (entry_i.ls_type)
				`LS_TYPE_BYTE:   load_data_o = {{24{shifted[7]}}, shifted[7:0]};
				`LS_TYPE_HALF:   load_data_o = {{16{shifted[15]}}, shifted[15:0]};
				`LS_TYPE_WORD:   load_data_o = shifted;
				`LS_TYPE_BYTE_U: load_data_o = {24'd0, shifted[7:0]};
				`LS_TYPE_HALF_U: load_data_o = {16'd0, shifted[15:0]};
				default:         load_data_o = '0;
			endcase
		end
	end

endmodule

//--- lsu_req_format.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_format (
	input  lsu_pkg::ls_req_t req_i,
	output logic aligned_o,
	output lsu_pkg::word_t store_data_o,
	output lsu_pkg::wmask_t store_wmask_o
);

	always_comb
	begin
		aligned_o = 1'b0;
		store_data_o = '0;
		store_wmask_o = '0;
		case (req_i.ls_type)
			`LS_TYPE_BYTE:
			begin
				aligned_o = 1'b1;
				store_data_o = {4{req_i.wdata[7:0]}};
				store_wmask_o = 4'b0001 << req_i.addr[1:0];
			end
			`LS_TYPE_BYTE_U:
				aligned_o = 1'b1; // load only, no mask
			`LS_TYPE_HALF:
			begin
				aligned_o = ~req_i.addr[0];
				store_data_o = {2{req_i.wdata[15:0]}};
				store_wmask_o = 4'b0011 << {req_i.addr[1], 1'b0};
			end
			`LS_TYPE_HALF_U:
				aligned_o = ~req_i.addr[0];
			`LS_TYPE_WORD:
			begin
				aligned_o = (req_i.addr[1:0] == 2'b00);
				store_data_o = req_i.wdata;
				store_wmask_o = 4'b1111;
			end
			default:
				aligned_o = 1'b0; // reserved codes never match
		endcase
	end

	// unsigned codes exist only for loads and must never write
	always_comb
	begin
		if ((req_i.ls_type == `LS_TYPE_BYTE_U) || (req_i.ls_type == `LS_TYPE_HALF_U))
			assert (store_wmask_o == '0)
			else $error("write mask set for a load-only access type");
	end

endmodule

//--- lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [2:0] ls_type_t;
	typedef logic [1:0] err_t;
	typedef logic [4:0] reg_id_t;
	typedef logic [`LSU_INST_ID_W-1:0] inst_id_t;
	typedef logic [3:0] wmask_t;

	typedef struct packed {
		logic is_store; // 0 load, 1 store
		ls_type_t ls_type;
		reg_id_t rd_id;
		word_t addr;
		word_t wdata;
		inst_id_t inst_id;
	} ls_req_t;

	typedef struct packed {
		logic is_store;
		reg_id_t rd_id;
		word_t data;
		word_t addr;
		err_t err;
		inst_id_t inst_id;
	} ls_resp_t;

	typedef struct packed {
		word_t addr;
		logic read;
		word_t wdata;
		wmask_t wmask;
	} icb_cmd_t;

	typedef struct packed {
		word_t rdata;
		logic err;
	} icb_rsp_t;

	// one outstanding access
	typedef struct packed {
		logic is_store;
		ls_type_t ls_type;
		reg_id_t rd_id;
		word_t addr;
		word_t data; // store data until a load response replaces it
		wmask_t wmask;
		err_t err;
		inst_id_t inst_id;
	} ls_entry_t;

	typedef enum logic [1:0] {
		STAGE_FREE,
		STAGE_CMD,
		STAGE_RESP,
		STAGE_DONE
	} task_stage_e;

endpackage

//--- lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// table geometry
`define LSU_INST_ID_W 4
`define LSU_TABLE_DEPTH 4
`define LSU_PTR_W 2
`define LSU_CNT_W 3

`define LSU_TIMEOUT_TH 16 // response wait cycles before a timeout (1 or more)

// access types
`define LS_TYPE_BYTE 3'b000
`define LS_TYPE_HALF 3'b001
`define LS_TYPE_WORD 3'b010
`define LS_TYPE_BYTE_U 3'b100
`define LS_TYPE_HALF_U 3'b101

// result error codes
`define ERR_NORMAL 2'b00
`define ERR_UNALIGNED 2'b01
`define ERR_BUS 2'b10
`define ERR_TIMEOUT 2'b11

`endif
